// ==== compile.f ====
+incdir+logic
logic/obj_table_pkg.sv
logic/obj_video_pkg.sv
logic/obj_scan_engine.sv
logic/obj_line_buffer.sv
logic/obj_pixel_out.sv
logic/obj_top.sv
verif/obj_tb_chk.sv
verif/obj_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= obj_tb
FILELIST  ?= compile.f
MDIR      ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)
	@out=$$(./$(MDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(MDIR)

// ==== verif/obj_tb.sv ====
`default_nettype none

`include "obj_settings.svh"

module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import obj_table_pkg::*;
    import obj_video_pkg::*;

    localparam int LIMIT = 40 * 1200;   // lines times cycles per line

    logic                    clk = 1'b0;
    logic                    rst;
    obj_timing_t             timing;
    logic                    pxl_cen;
    logic [`OBJ_SCAN_AW-1:0] scan_addr;
    logic [7:0]              scan_data;
    obj_rom_req_t            rom;
    logic                    rom_ok;
    logic [15:0]             rom_data;
    obj_pxl_t                pixel;
    logic                    opaque;
    logic                    done;

    logic [7:0]  oram [1 << `OBJ_SCAN_AW];
    logic [17:0] req_q [$];
    logic [17:0] exp_req [4];
    obj_pxl_t    line_px [512];
    logic        line_op [512];
    obj_pxl_t    exp_px [512];
    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    int          rom_delay;
    logic        rom_armed;

    obj_top DUT (
        .clk(clk), .rst(rst), .timing(timing), .pxl_cen(pxl_cen),
        .scan_addr(scan_addr), .scan_data(scan_data), .rom(rom), .rom_ok(rom_ok),
        .rom_data(rom_data), .pixel(pixel), .opaque(opaque), .done(done)
    );

    bind obj_scan_engine obj_tb_chk u_chk (
        .clk(clk), .rst(rst), .rom(rom), .rom_ok(rom_ok), .wr_en(wr_en), .done(done)
    );

    always #4 clk = ~clk;

    assign scan_data = oram[scan_addr];   // object RAM answers in the same cycle

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run stopped at the cycle limit of %0d", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [15:0] rom_word(logic [17:0] a);
        return a[15:0] ^ {a[17:16], a[17:4]} ^ 16'h7b3d;
    endfunction

    // ROM with 0 to 5 cycles of latency
    always @(negedge clk) begin
        if (rst || !rom.cs) begin
            rom_ok    = 1'b0;
            rom_armed = 1'b0;
        end else if (!rom_armed) begin
            rom_armed = 1'b1;
            rom_delay = $urandom % 6;
            req_q.push_back(rom.addr);
            rom_data  = rom_word(rom.addr);
            rom_ok    = (rom_delay == 0);
        end else if (!rom_ok) begin
            rom_delay = rom_delay - 1;
            rom_ok    = (rom_delay == 0);
        end
    end

    task automatic check_pxl(string name, obj_pxl_t got, obj_pxl_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rom(string name, obj_rom_req_t got, obj_rom_req_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic clear_table();
        int a;
        for (a = 0; a < (1 << `OBJ_SCAN_AW); a++) begin
            oram[a] = 8'(a ^ (a >> 3) ^ (a >> 8));
        end
        for (a = 0; a < `OBJ_ENTRIES; a++) begin
            oram[a * `OBJ_STRIDE + 2] = 8'd250;   // below every test line
        end
    endtask

    task automatic put_sprite(int e, logic [8:0] x, logic [7:0] y, logic hf, logic vf);
        int b;
        b = e * `OBJ_STRIDE;
        oram[b]     = 8'h3c;
        oram[b + 1] = {4'h9, 4'h2};
        oram[b + 2] = y;
        oram[b + 3] = x[7:0];
        oram[b + 4] = {2'b01, vf, hf, 3'd0, x[8]};   // 16x16
    endtask

    task automatic zero_expect();
        int h;
        for (h = 0; h < 512; h++) exp_px[h] = '0;
    endtask

    // expected pixels and ROM requests of the sprite from put_sprite
    task automatic expect_sprite(logic [8:0] x, logic [7:0] y, logic [8:0] vr,
                                 logic hf, logic vf);
        logic [4:0]  vs;
        logic [8:0]  xs;
        logic [1:0]  w;
        logic [17:0] a;
        logic [15:0] word;
        int          p;
        int          src;
        obj_pxl_t    px;
        vs = 5'(vr - {1'b0, y}) ^ (vf ? 5'd15 : 5'd0);
        xs = x + timing.dump_start - 9'd1;
        zero_expect();
        for (p = 0; p < 16; p++) begin
            src = hf ? 15 - p : p;
            w   = 2'(src / 4);
            a   = {2'b01, 2'b10, 8'h3c, vs[3], w[1], vs[2:0], w[0]};
            word   = rom_word(a);
            px.col = word[4 * (3 - src % 4) +: 4];
            px.pal = (px.col != 4'd0) ? 4'h9 : 4'h0;   // colour 0 is never written
            exp_px[9'(xs + 9'(p))] = px;
            if (p % 4 == 0) exp_req[p / 4] = a;
        end
    endtask

    task automatic run_line(logic [8:0] vr);
        int i;
        int waited;
        @(negedge clk);
        timing.lhbl    = 1'b0;
        timing.lvbl    = 1'b1;   // active frame
        timing.vrender = vr;
        pxl_cen        = 1'b0;
        repeat (4) @(negedge clk);
        req_q.delete();
        timing.lhbl = 1'b1;   // line start
        for (i = 0; i < 514; i++) begin
            @(negedge clk);
            if (i == 0) check_bit("done", done, 1'b0);
            if (i >= 2) begin
                line_px[i - 2] = pixel;   // pixel lags pxl_cen by 2 cycles
                line_op[i - 2] = opaque;
            end
            pxl_cen      = (i < 512);
            timing.hdump = 9'(i);
        end
        waited = 0;
        while (!done && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            failures++;
            $display("engine did not finish the scan of line %0d", vr);
        end
    endtask

    task automatic compare_line();
        int h;
        for (h = 0; h < 512; h++) begin
            check_pxl($sformatf("pixel[%0d]", h), line_px[h], exp_px[h]);
            check_bit($sformatf("opaque[%0d]", h), line_op[h], exp_px[h].col != 4'd0);
        end
    endtask

    task automatic compare_requests();
        int i;
        if (req_q.size() != 4) begin
            failures++;
            $display("expected 4 ROM requests, saw %0d", req_q.size());
        end else begin
            for (i = 0; i < 4; i++) begin
                check_rom($sformatf("rom request %0d", i), {1'b1, req_q[i]}, {1'b1, exp_req[i]});
            end
        end
    endtask

    task automatic test_reset();
        check_bit("done", done, 1'b1);
        check_bit("rom.cs", rom.cs, 1'b0);
        check_pxl("pixel", pixel, '0);
        check_bit("opaque", opaque, 1'b0);
    endtask

    task automatic test_sprite(logic hf, logic vf);
        clear_table();
        put_sprite(5, 9'd40, 8'd50, hf, vf);
        expect_sprite(9'd40, 8'd50, 9'd55, hf, vf);
        run_line(9'd55);
        compare_requests();
        clear_table();
        run_line(9'd56);   // drawn half is now on display
        compare_line();
    endtask

    task automatic test_no_hit(int e, logic end_marker);
        clear_table();
        if (end_marker) oram[16 * `OBJ_STRIDE + 2] = 8'(`OBJ_END_Y);
        put_sprite(e, 9'd40, end_marker ? 8'd50 : 8'd80, 1'b0, 1'b0);
        zero_expect();
        run_line(9'd55);
        if (req_q.size() != 0) begin
            failures++;
            $display("sprite that should not draw fetched %0d ROM words", req_q.size());
        end
        clear_table();
        run_line(9'd56);
        compare_line();
    endtask

    task automatic test_read_clear();
        test_sprite(1'b0, 1'b0);
        zero_expect();
        run_line(9'd57);
        compare_line();
        run_line(9'd58);   // same half again, cleared by the earlier readout
        compare_line();
    endtask

    initial begin
        void'($urandom(18047));
        clear_table();
        rst               = 1'b1;
        timing            = '0;
        timing.dump_start = 9'd20;
        pxl_cen           = 1'b0;
        rom_ok            = 1'b0;
        rom_data          = '0;
        rom_armed         = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset();
        run_line(9'd0);   // sweep both halves once to clear the buffer
        run_line(9'd0);
        test_sprite(1'b0, 1'b0);
        test_sprite(1'b1, 1'b0);
        test_sprite(1'b0, 1'b1);
        test_no_hit(5, 1'b0);
        test_no_hit(20, 1'b1);
        test_read_clear();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/obj_tb_chk.sv ====
`default_nettype none

module obj_tb_chk (
    input wire                               clk,
    input wire                               rst,
    input wire obj_video_pkg::obj_rom_req_t  rom,
    input wire                               rom_ok,
    input wire                               wr_en,
    input wire                               done
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held with a stable address until the ROM answers
    property cs_held;
        @(posedge clk) disable iff (rst)
            rom.cs && !rom_ok |=> rom.cs && $stable(rom.addr);
    endproperty

    property no_write_when_done;
        @(posedge clk) disable iff (rst) wr_en |-> !done;
    endproperty

    cs_held_a: assert property (cs_held)
        else $error("rom cs dropped or address moved before rom_ok");
    no_write_a: assert property (no_write_when_done)
        else $error("line buffer write while engine is done");

endmodule

`default_nettype wire

// ==== logic/obj_top.sv ====
`default_nettype none

`include "obj_settings.svh"

module obj_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire obj_video_pkg::obj_timing_t timing,
    input  wire                             pxl_cen,
    output logic [`OBJ_SCAN_AW-1:0]         scan_addr,
    input  wire  [7:0]                      scan_data,
    output obj_video_pkg::obj_rom_req_t     rom,
    input  wire                             rom_ok,
    input  wire  [15:0]                     rom_data,
    output obj_video_pkg::obj_pxl_t         pixel,
    output logic                            opaque,
    output logic                            done
);
    import obj_video_pkg::*;

    obj_wr_t  wr;
    logic     wr_en;
    logic     half;
    obj_pxl_t rd_data;

    obj_scan_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .timing    (timing),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .rom       (rom),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .wr        (wr),
        .wr_en     (wr_en),
        .half      (half),
        .done      (done)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .wr      (wr),
        .wr_en   (wr_en),
        .half    (half),
        .hdump   (timing.hdump),
        .pxl_cen (pxl_cen),
        .rd_data (rd_data)
    );

    obj_pixel_out u_out (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .rd_data (rd_data),
        .pixel   (pixel),
        .opaque  (opaque)
    );

endmodule

`default_nettype wire

// ==== logic/obj_pixel_out.sv ====
`default_nettype none

module obj_pixel_out (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire obj_video_pkg::obj_pxl_t rd_data,
    output obj_video_pkg::obj_pxl_t      pixel,
    output logic                         opaque
);
    logic cen_d;   // buffer data valid

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_d  <= 1'b0;
            pixel  <= '0;
            opaque <= 1'b0;
        end else begin
            cen_d <= pxl_cen;
            if (cen_d) begin
                pixel  <= rd_data;
                opaque <= rd_data.col != 4'd0;   // colour 0 shows through
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/obj_line_buffer.sv ====
`default_nettype none

`include "obj_settings.svh"

module obj_line_buffer (
    input  wire                         clk,
    input  wire obj_video_pkg::obj_wr_t wr,
    input  wire                         wr_en,
    input  wire                         half,      // draw half
    input  wire  [`OBJ_LINE_W-1:0]      hdump,
    input  wire                         pxl_cen,
    output obj_video_pkg::obj_pxl_t     rd_data
);
    import obj_video_pkg::*;

    localparam int DEPTH = 2 ** (`OBJ_LINE_W + 1);   // two line halves

    obj_pxl_t               mem [DEPTH];
    logic [`OBJ_LINE_W:0]   wr_addr;
    logic [`OBJ_LINE_W:0]   rd_addr;
    logic                   wr_ok;

    assign wr_addr = {wr.half, wr.x};
    assign rd_addr = {~half, hdump};          // display reads the other half
    assign wr_ok   = wr_en && (wr.pxl.col != 4'd0);   // colour 0 leaves the pixel behind

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_addr] <= wr.pxl;
        end
        if (pxl_cen) begin
            rd_data      <= mem[rd_addr];
            mem[rd_addr] <= '0;               // clear once shown
        end
    end

endmodule

`default_nettype wire

// ==== logic/obj_scan_engine.sv ====
`default_nettype none

`include "obj_settings.svh"

module obj_scan_engine (
    input  wire                           clk,
    input  wire                           rst,
    input  wire obj_video_pkg::obj_timing_t timing,
    output logic [`OBJ_SCAN_AW-1:0]       scan_addr,
    input  wire  [7:0]                    scan_data,
    output obj_video_pkg::obj_rom_req_t   rom,
    input  wire                           rom_ok,
    input  wire  [15:0]                   rom_data,
    output obj_video_pkg::obj_wr_t        wr,
    output logic                          wr_en,
    output logic                          half,
    output logic                          done
);
    import obj_table_pkg::*;
    import obj_video_pkg::*;

    localparam int LAST_BASE    = (`OBJ_ENTRIES - 1) * `OBJ_STRIDE;
    localparam int END_MIN_BASE = 16 * `OBJ_STRIDE;   // end marker honoured from entry 16

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ATTR,
        ST_Y,
        ST_CODE,
        ST_COLOUR,
        ST_X,
        ST_ROM,
        ST_DRAW,
        ST_STEP,
        ST_NEXT
    } state_e;

    state_e                  st;
    logic                    last_lhbl;
    logic                    line_start;
    logic [`OBJ_SCAN_AW-1:0] base;
    logic [2:0]              byte_sel;
    obj_attr_u               attr;
    obj_entry_t              ent;
    logic                    rom_cs;
    logic                    h4;        // half word within the pair
    logic [4:0]              vsub;      // row inside the sprite
    logic [2:0]              wcnt;
    logic [2:0]              wlast;
    logic [1:0]              dcnt;
    logic [15:0]             pxl_data;
    logic [`OBJ_LINE_W-1:0]  xpos;
    logic [9:0]              pxl_cnt;
    logic [5:0]              height;
    logic [4:0]              row_mask;
    logic [`OBJ_LINE_W-1:0]  vdiff;
    logic                    hit;
    logic                    size32;

    assign line_start = timing.lhbl && !last_lhbl && timing.lvbl;
    assign scan_addr  = base + {7'd0, byte_sel};
    assign attr       = scan_data;       // same byte, two readings

    assign size32   = obj_is32(ent.size);
    assign height   = obj_height(ent.size);
    assign row_mask = height[4:0] - 5'd1;
    assign vdiff    = timing.vrender - {1'b0, scan_data};
    assign hit      = (timing.vrender >= {1'b0, scan_data}) && (vdiff < {3'd0, height});

    assign rom.cs   = rom_cs;
    assign rom.addr = {ent.code, vsub[2:0], h4};   // 14+3+1

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= ST_IDLE;
            done      <= 1'b1;
            rom_cs    <= 1'b0;
            wr_en     <= 1'b0;
            half      <= 1'b0;
            last_lhbl <= 1'b0;
            base      <= '0;
            byte_sel  <= 3'd4;
        end else begin
            last_lhbl <= timing.lhbl;
            wr_en     <= 1'b0;
            if (line_start) begin
                done     <= 1'b0;
                rom_cs   <= 1'b0;
                half     <= ~half;       // swap draw and display halves
                base     <= '0;
                byte_sel <= 3'd4;        // size and flip byte first
                pxl_cnt  <= '0;
                st       <= ST_ATTR;
            end else begin
                case (st)
                    ST_ATTR: begin
                        ent.code[13:12] <= attr.size_view.code_hi;
                        ent.vflip       <= attr.size_view.vflip;
                        ent.hflip       <= attr.size_view.hflip;
                        ent.size        <= attr.size_view.size;
                        ent.x_msb       <= attr.size_view.x_msb;
                        byte_sel        <= 3'd2;   // y next
                        st              <= ST_Y;
                    end
                    ST_Y: begin
                        vsub <= vdiff[4:0] ^ ({5{ent.vflip}} & row_mask);
                        if (scan_data == 8'(`OBJ_END_Y) && base >= END_MIN_BASE) begin
                            done <= 1'b1;
                            st   <= ST_IDLE;
                        end else if (hit) begin
                            byte_sel <= 3'd0;
                            st       <= ST_CODE;
                        end else begin
                            st <= ST_NEXT;           // not on this line
                        end
                    end
                    ST_CODE: begin
                        ent.code[9:2] <= scan_data;
                        byte_sel      <= 3'd1;
                        st            <= ST_COLOUR;
                    end
                    ST_COLOUR: begin
                        ent.pal         <= attr.colour_view.pal;
                        ent.code[11:10] <= attr.colour_view.code_ext[1:0];
                        // vertical tile select
                        if (size32)
                            {ent.code[3], ent.code[1]} <= vsub[4:3];
                        else if (height == 6'd8)
                            ent.code[1] <= attr.colour_view.code_ext[3];
                        else
                            ent.code[1] <= vsub[3];
                        // horizontal tile select, start from the right when flipped
                        if (size32)
                            {ent.code[2], ent.code[0]} <= {2{ent.hflip}};
                        else if (obj_last_word(ent.size) == 3'd1)
                            ent.code[0] <= attr.colour_view.code_ext[2];
                        else
                            ent.code[0] <= ent.hflip;
                        h4       <= ent.hflip;
                        wcnt     <= 3'd0;
                        wlast    <= obj_last_word(ent.size);
                        byte_sel <= 3'd3;
                        st       <= ST_X;
                    end
                    ST_X: begin
                        xpos   <= {ent.x_msb, scan_data} + timing.dump_start - 9'd1;
                        rom_cs <= 1'b1;
                        st     <= ST_ROM;
                    end
                    ST_ROM: begin
                        if (rom_ok) begin        // otherwise hold
                            pxl_data <= rom_data;
                            rom_cs   <= 1'b0;
                            dcnt     <= 2'd0;
                            st       <= ST_DRAW;
                        end
                    end
                    ST_DRAW: begin
                        wr_en      <= 1'b1;
                        wr.half    <= half;
                        wr.x       <= xpos;
                        wr.pxl.pal <= ent.pal;
                        wr.pxl.col <= ent.hflip ? pxl_data[3:0] : pxl_data[15:12];
                        pxl_data   <= ent.hflip ? pxl_data >> 4 : pxl_data << 4;
                        xpos       <= xpos + 9'd1;   // wraps at 512
                        pxl_cnt    <= pxl_cnt + 10'd1;
                        dcnt       <= dcnt + 2'd1;
                        if (dcnt == 2'd3) st <= ST_STEP;
                    end
                    ST_STEP: begin
                        {ent.code[2], ent.code[0], h4} <=
                            {ent.code[2], ent.code[0], h4} + (ent.hflip ? 3'b111 : 3'b001);
                        wcnt <= wcnt + 3'd1;
                        if (wcnt == wlast) begin
                            st <= ST_NEXT;           // row complete
                        end else begin
                            rom_cs <= 1'b1;
                            st     <= ST_ROM;
                        end
                    end
                    ST_NEXT: begin
                        byte_sel <= 3'd4;
                        if (base < LAST_BASE && pxl_cnt < `OBJ_PXL_LIMIT) begin
                            base <= base + `OBJ_SCAN_AW'(`OBJ_STRIDE);
                            st   <= ST_ATTR;
                        end else begin
                            done <= 1'b1;
                            st   <= ST_IDLE;
                        end
                    end
                    default: st <= ST_IDLE;  // idle until next line start
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/obj_video_pkg.sv ====
`default_nettype none

`include "obj_settings.svh"

package obj_video_pkg;

    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;    // 0 is transparent
    } obj_pxl_t;

    // one line buffer write
    typedef struct packed {
        logic                   half;
        logic [`OBJ_LINE_W-1:0] x;
        obj_pxl_t               pxl;
    } obj_wr_t;

    typedef struct packed {
        logic        cs;
        logic [17:0] addr;  // code, row, half word
    } obj_rom_req_t;

    typedef struct packed {
        logic                   lhbl;
        logic                   lvbl;
        logic [`OBJ_LINE_W-1:0] vrender;     // line being prepared
        logic [`OBJ_LINE_W-1:0] hdump;       // pixel on display
        logic [`OBJ_LINE_W-1:0] dump_start;
    } obj_timing_t;

endpackage

`default_nettype wire

// ==== logic/obj_table_pkg.sv ====
`default_nettype none

package obj_table_pkg;

    typedef enum logic [2:0] {
        SIZE_16 = 3'd0,   // 16x16
        SIZE_8H = 3'd1,   // 16 wide, 8 tall
        SIZE_8V = 3'd2,   // 8 wide, 16 tall
        SIZE_8  = 3'd3    // 8x8, bit 2 set means 32x32
    } obj_size_e;

    // byte at offset 4
    typedef struct packed {
        logic [1:0] code_hi;
        logic       vflip;
        logic       hflip;
        obj_size_e  size;
        logic       x_msb;
    } obj_size_view_t;

    // byte at offset 1
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] code_ext;
    } obj_colour_view_t;

    typedef union packed {
        obj_size_view_t   size_view;
        obj_colour_view_t colour_view;
    } obj_attr_u;

    // decoded entry as held by the engine while drawing
    typedef struct packed {
        logic [13:0] code;
        logic [3:0]  pal;
        obj_size_e   size;
        logic        hflip;
        logic        vflip;
        logic        x_msb;
    } obj_entry_t;

    function automatic logic obj_is32(obj_size_e size);
        logic [2:0] s;
        s = size;
        return s[2];
    endfunction

    function automatic logic [5:0] obj_height(obj_size_e size);
        logic [5:0] h;
        if (obj_is32(size)) h = 6'd32;
        else if (size == SIZE_8H || size == SIZE_8) h = 6'd8;
        else h = 6'd16;
        return h;
    endfunction

    // index of the last ROM word in a row, 4 pixels per word
    function automatic logic [2:0] obj_last_word(obj_size_e size);
        logic [2:0] w;
        if (obj_is32(size)) w = 3'd7;
        else if (size == SIZE_8V || size == SIZE_8) w = 3'd1;
        else w = 3'd3;
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== logic/obj_settings.svh ====
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// sprite table geometry
`define OBJ_ENTRIES 64       // entries per table
`define OBJ_STRIDE 5         // bytes per entry
`define OBJ_SCAN_AW 10       // object RAM address bits

// line geometry
`define OBJ_LINE_W 9         // x coordinate bits
`define OBJ_PXL_LIMIT 384    // pixels drawn per line at most

// y value of the entry that closes the table
`define OBJ_END_Y 240

`endif
